/* include/bpmon_config.svh */
`ifndef BPMON_CONFIG_SVH
`define BPMON_CONFIG_SVH

// width of every counter and path signature
`define BPMON_CNT_W 32

// feedback taps of the path signature
`define BPMON_SIG_POLY 32'h0017beaf

// event classes, index order
// 0 ball (any), 1 brop, 2 jrop, 3 jrra
`define BPMON_NUM_CLASS 4

// register map byte address width
// word index = class * 8 + kind
`define BPMON_ADDR_W 8

`endif

/* verilog/bpmon_pkg.sv */
`include "bpmon_config.svh"

package bpmon_pkg;

    typedef logic [`BPMON_CNT_W-1:0] cnt_t;
    typedef logic [`BPMON_CNT_W-1:0] sig_t;
    typedef logic [31:0] pc_t;

    // one element per class, ball at index 0
    typedef cnt_t [`BPMON_NUM_CLASS-1:0] class_cnt_t;
    typedef sig_t [`BPMON_NUM_CLASS-1:0] class_sig_t;

    // one branch event of a pipeline stage, flags are one-hot or none
    typedef struct packed {
        logic brop;
        logic jrop;
        logic jrra;
        logic cancel;
        pc_t  pc;
    } stage_evt_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        DECERR = 2'b11
    } resp_t;

    typedef struct packed {
        logic                    arvalid;
        logic [`BPMON_ADDR_W-1:0] araddr;
    } axil_ar_t;

    typedef struct packed {
        logic                   rvalid;
        logic [`BPMON_CNT_W-1:0] rdata;
        resp_t                  rresp;
    } axil_r_t;

    typedef enum logic {
        RD_IDLE,
        RD_DATA
    } rd_state_e;

    // shift, fold in the polynomial on carry-out, then mix the pc
    function automatic sig_t sig_step(input sig_t old_sig, input pc_t pc);
        sig_t fold;
        fold = {`BPMON_CNT_W{old_sig[`BPMON_CNT_W-1]}} & `BPMON_SIG_POLY;
        return {old_sig[`BPMON_CNT_W-2:0], 1'b0} ^ fold ^ pc;
    endfunction

endpackage

/* verilog/bpmon_wb_tracker.sv */
`timescale 1ns/1ps
`include "bpmon_config.svh"

module bpmon_wb_tracker (
    input  logic                  clock,
    input  logic                  reset,
    input  bpmon_pkg::stage_evt_t i_wb,
    output bpmon_pkg::class_cnt_t o_wb_cnt,
    output bpmon_pkg::class_cnt_t o_wb_cnt_next,
    output bpmon_pkg::class_sig_t o_wb_sig,
    output bpmon_pkg::class_sig_t o_wb_sig_next
);

    logic [`BPMON_NUM_CLASS-1:0] hit;
    bpmon_pkg::class_cnt_t       cnt_q;
    bpmon_pkg::class_sig_t       sig_q;

    // class hits, index 0 is any flag
    assign hit = {i_wb.jrra, i_wb.jrop, i_wb.brop, i_wb.brop | i_wb.jrop | i_wb.jrra};

    // next committed state, also the restore point of the br tracker
    always_comb
    begin
        for (int c = 0; c < `BPMON_NUM_CLASS; c++)
        begin
            if (hit[c])
            begin
                o_wb_cnt_next[c] = cnt_q[c] + bpmon_pkg::cnt_t'(1);
                o_wb_sig_next[c] = bpmon_pkg::sig_step(sig_q[c], i_wb.pc);
            end
            else
            begin
                o_wb_cnt_next[c] = cnt_q[c];
                o_wb_sig_next[c] = sig_q[c];
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            cnt_q <= '0;
            sig_q <= '0;
        end
        else
        begin
            cnt_q <= o_wb_cnt_next;
            sig_q <= o_wb_sig_next;
        end
    end

    assign o_wb_cnt = cnt_q;
    assign o_wb_sig = sig_q;

    // committed total must match the per-class split
    a_wb_ball_sum : assert property (
        @(posedge clock) disable iff (reset)
        cnt_q[0] == cnt_q[1] + cnt_q[2] + cnt_q[3]
    ) else $error("wb ball count differs from class sum");

endmodule

/* verilog/bpmon_br_tracker.sv */
`timescale 1ns/1ps
`include "bpmon_config.svh"

module bpmon_br_tracker (
    input  logic                  clock,
    input  logic                  reset,
    input  bpmon_pkg::stage_evt_t i_br,
    input  logic                  i_wb_cancel,
    input  bpmon_pkg::class_cnt_t i_wb_cnt_next,
    input  bpmon_pkg::class_sig_t i_wb_sig_next,
    output bpmon_pkg::class_cnt_t o_br_cnt,
    output bpmon_pkg::class_cnt_t o_br_err,
    output bpmon_pkg::class_cnt_t o_br_rec,
    output bpmon_pkg::class_sig_t o_br_sig
);

    logic [`BPMON_NUM_CLASS-1:0] hit;
    bpmon_pkg::class_cnt_t       cnt_q;
    bpmon_pkg::class_cnt_t       err_q;
    bpmon_pkg::class_cnt_t       rec_q;
    bpmon_pkg::class_sig_t       sig_q;

    assign hit = {i_br.jrra, i_br.jrop, i_br.brop, i_br.brop | i_br.jrop | i_br.jrra};

    // totals and mispredicts, never rolled back
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            cnt_q <= '0;
            err_q <= '0;
        end
        else
        begin
            for (int c = 0; c < `BPMON_NUM_CLASS; c++)
            begin
                if (hit[c])
                begin
                    cnt_q[c] <= cnt_q[c] + bpmon_pkg::cnt_t'(1);
                    if (i_br.cancel)
                    begin
                        err_q[c] <= err_q[c] + bpmon_pkg::cnt_t'(1);
                    end
                end
            end
        end
    end

    // speculative history
    // a wb flush wins over a br event in the same cycle
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            rec_q <= '0;
            sig_q <= '0;
        end
        else
        begin
            for (int c = 0; c < `BPMON_NUM_CLASS; c++)
            begin
                if (i_wb_cancel)
                begin
                    rec_q[c] <= i_wb_cnt_next[c];
                    sig_q[c] <= i_wb_sig_next[c];
                end
                else if (hit[c])
                begin
                    rec_q[c] <= rec_q[c] + bpmon_pkg::cnt_t'(1);
                    sig_q[c] <= bpmon_pkg::sig_step(sig_q[c], i_br.pc);
                end
            end
        end
    end

    assign o_br_cnt = cnt_q;
    assign o_br_err = err_q;
    assign o_br_rec = rec_q;
    assign o_br_sig = sig_q;

    a_br_flags_onehot : assert property (
        @(posedge clock) disable iff (reset)
        $onehot0({i_br.brop, i_br.jrop, i_br.jrra})
    ) else $error("br event carries more than one class flag");

    // a mispredict redirects, so the next resolve slot cannot cancel too
    a_br_cancel_single : assert property (
        @(posedge clock) disable iff (reset)
        i_br.cancel |=> !i_br.cancel
    ) else $error("br cancel high on two consecutive cycles");

endmodule

/* verilog/bpmon_axil_regs.sv */
`timescale 1ns/1ps
`include "bpmon_config.svh"

module bpmon_axil_regs (
    input  logic                  clock,
    input  logic                  reset,
    input  bpmon_pkg::axil_ar_t   i_ar,
    output logic                  o_arready,
    output bpmon_pkg::axil_r_t    o_r,
    input  logic                  i_rready,
    input  bpmon_pkg::class_cnt_t i_wb_cnt,
    input  bpmon_pkg::class_cnt_t i_br_cnt,
    input  bpmon_pkg::class_cnt_t i_br_err,
    input  bpmon_pkg::class_cnt_t i_br_rec,
    input  bpmon_pkg::class_sig_t i_wb_sig,
    input  bpmon_pkg::class_sig_t i_br_sig
);

    localparam int CLS_W = $clog2(`BPMON_NUM_CLASS);

    bpmon_pkg::rd_state_e        state;
    logic [`BPMON_ADDR_W-6:0]    addr_class;
    logic [2:0]                  addr_kind;
    logic [CLS_W-1:0]            cls;
    logic                        mapped;
    logic [`BPMON_CNT_W-1:0]     rd_data;
    bpmon_pkg::resp_t            rd_resp;
    logic [`BPMON_CNT_W-1:0]     data_q;
    bpmon_pkg::resp_t            resp_q;

    // byte address = {class, kind, 2'b00}
    assign addr_class = i_ar.araddr[`BPMON_ADDR_W-1:5];
    assign addr_kind  = i_ar.araddr[4:2];
    assign cls        = addr_class[CLS_W-1:0];
    assign mapped     = (i_ar.araddr[1:0] == 2'b00) && (addr_class < `BPMON_NUM_CLASS);

    always_comb
    begin
        rd_data = '0;
        rd_resp = bpmon_pkg::DECERR;
        if (mapped)
        begin
            rd_resp = bpmon_pkg::OKAY;
            case (addr_kind)
                3'd0: rd_data = i_wb_cnt[cls];
                3'd1: rd_data = i_wb_sig[cls];
                3'd2: rd_data = i_br_cnt[cls];
                3'd3: rd_data = i_br_err[cls];
                3'd4: rd_data = i_br_rec[cls];
                3'd5: rd_data = i_br_sig[cls];
                default: rd_resp = bpmon_pkg::DECERR;
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= bpmon_pkg::RD_IDLE;
        end
        else
        begin
            case (state)
                bpmon_pkg::RD_IDLE: if (i_ar.arvalid) state <= bpmon_pkg::RD_DATA;
                bpmon_pkg::RD_DATA: if (i_rready) state <= bpmon_pkg::RD_IDLE;
                default: state <= bpmon_pkg::RD_IDLE;
            endcase
        end
    end

    // snapshot at address acceptance, held through any stall
    always_ff @(posedge clock)
    begin
        if (state == bpmon_pkg::RD_IDLE && i_ar.arvalid)
        begin
            data_q <= rd_data;
            resp_q <= rd_resp;
        end
    end

    assign o_arready = (state == bpmon_pkg::RD_IDLE);
    assign o_r.rvalid = (state == bpmon_pkg::RD_DATA);
    assign o_r.rdata  = data_q;
    assign o_r.rresp  = resp_q;

    a_r_stable : assert property (
        @(posedge clock) disable iff (reset)
        o_r.rvalid && !i_rready |=> o_r.rvalid && $stable(o_r.rdata) && $stable(o_r.rresp)
    ) else $error("read response changed while stalled");

endmodule

/* verilog/bpmon_top.sv */
`timescale 1ns/1ps

module bpmon_top (
    input  logic                  clock,
    input  logic                  reset,
    input  bpmon_pkg::stage_evt_t i_br,
    input  bpmon_pkg::stage_evt_t i_wb,
    input  bpmon_pkg::axil_ar_t   i_ar,
    output logic                  o_arready,
    output bpmon_pkg::axil_r_t    o_r,
    input  logic                  i_rready
);

    bpmon_pkg::class_cnt_t wb_cnt;
    bpmon_pkg::class_cnt_t wb_cnt_next;
    bpmon_pkg::class_sig_t wb_sig;
    bpmon_pkg::class_sig_t wb_sig_next;
    bpmon_pkg::class_cnt_t br_cnt;
    bpmon_pkg::class_cnt_t br_err;
    bpmon_pkg::class_cnt_t br_rec;
    bpmon_pkg::class_sig_t br_sig;

    bpmon_wb_tracker u_wb (
        .clock         (clock),
        .reset         (reset),
        .i_wb          (i_wb),
        .o_wb_cnt      (wb_cnt),
        .o_wb_cnt_next (wb_cnt_next),
        .o_wb_sig      (wb_sig),
        .o_wb_sig_next (wb_sig_next)
    );

    // flush restores speculative state from committed history
    bpmon_br_tracker u_br (
        .clock         (clock),
        .reset         (reset),
        .i_br          (i_br),
        .i_wb_cancel   (i_wb.cancel),
        .i_wb_cnt_next (wb_cnt_next),
        .i_wb_sig_next (wb_sig_next),
        .o_br_cnt      (br_cnt),
        .o_br_err      (br_err),
        .o_br_rec      (br_rec),
        .o_br_sig      (br_sig)
    );

    bpmon_axil_regs u_regs (
        .clock     (clock),
        .reset     (reset),
        .i_ar      (i_ar),
        .o_arready (o_arready),
        .o_r       (o_r),
        .i_rready  (i_rready),
        .i_wb_cnt  (wb_cnt),
        .i_br_cnt  (br_cnt),
        .i_br_err  (br_err),
        .i_br_rec  (br_rec),
        .i_wb_sig  (wb_sig),
        .i_br_sig  (br_sig)
    );

endmodule

/* tb/bpmon_tb.sv */
`timescale 1ns/1ps
`include "bpmon_config.svh"

module bpmon_tb;

    localparam int WAIT_LIMIT = 100;

    logic                  clock;
    logic                  reset;
    bpmon_pkg::stage_evt_t br_evt;
    bpmon_pkg::stage_evt_t wb_evt;
    bpmon_pkg::axil_ar_t   ar;
    logic                  arready;
    bpmon_pkg::axil_r_t    r;
    logic                  rready;
    logic [31:0]           lfsr;
    logic                  prev_br_cancel;
    string                 kind_names [6] = '{"wb_cnt", "wb_sig", "br_cnt", "br_err",
                                              "br_rec", "br_sig"};

    // reference state, one copy per register kind
    bpmon_pkg::class_cnt_t m_wb_cnt;
    bpmon_pkg::class_sig_t m_wb_sig;
    bpmon_pkg::class_cnt_t m_br_cnt;
    bpmon_pkg::class_cnt_t m_br_err;
    bpmon_pkg::class_cnt_t m_br_rec;
    bpmon_pkg::class_sig_t m_br_sig;

    bpmon_top u_dut (
        .clock     (clock),
        .reset     (reset),
        .i_br      (br_evt),
        .i_wb      (wb_evt),
        .i_ar      (ar),
        .o_arready (arready),
        .o_r       (r),
        .i_rready  (rready)
    );

    always #4 clock = ~clock;

    // galois lfsr, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic bpmon_pkg::stage_evt_t make_event(input logic [1:0] sel,
                                                         input bpmon_pkg::pc_t pc);
        bpmon_pkg::stage_evt_t e;
        e = '0;
        e.pc = pc;
        e.brop = (sel == 2'd1);
        e.jrop = (sel == 2'd2);
        e.jrra = (sel == 2'd3);
        return e;
    endfunction

    // index 0 is the any-class total
    function automatic logic [3:0] class_hits(input bpmon_pkg::stage_evt_t e);
        return {e.jrra, e.jrop, e.brop, e.brop | e.jrop | e.jrra};
    endfunction

    task automatic model_update(input bpmon_pkg::stage_evt_t b, input bpmon_pkg::stage_evt_t w);
        logic [3:0] bh;
        logic [3:0] wh;
        bh = class_hits(b);
        wh = class_hits(w);
        for (int c = 0; c < `BPMON_NUM_CLASS; c++)
        begin
            if (wh[c])
            begin
                m_wb_cnt[c] = m_wb_cnt[c] + 1;
                m_wb_sig[c] = bpmon_pkg::sig_step(m_wb_sig[c], w.pc);
            end
            if (bh[c])
            begin
                m_br_cnt[c] = m_br_cnt[c] + 1;
                if (b.cancel)
                    m_br_err[c] = m_br_err[c] + 1;
            end
            // restore uses wb values that already hold this cycle's event
            if (w.cancel)
            begin
                m_br_rec[c] = m_wb_cnt[c];
                m_br_sig[c] = m_wb_sig[c];
            end
            else if (bh[c])
            begin
                m_br_rec[c] = m_br_rec[c] + 1;
                m_br_sig[c] = bpmon_pkg::sig_step(m_br_sig[c], b.pc);
            end
        end
    endtask

    task automatic drive_idle();
        br_evt = '0;
        wb_evt = '0;
        prev_br_cancel = 1'b0;
    endtask

    task automatic step_events(input bit br_ok, input bit wb_ok);
        logic [31:0]           sel;
        bpmon_pkg::stage_evt_t b;
        bpmon_pkg::stage_evt_t w;
        sel = take_bits(2);
        b = make_event(sel[1:0], take_bits(32));
        b.cancel = br_ok && !prev_br_cancel && (take_bits(2) == 32'd0);
        sel = take_bits(2);
        w = make_event(sel[1:0], take_bits(32));
        w.cancel = wb_ok && (take_bits(3) == 32'd0);
        prev_br_cancel = b.cancel;
        br_evt = b;
        wb_evt = w;
        model_update(b, w);
    endtask

    task automatic run_burst(input int n, input bit br_ok, input bit wb_ok);
        for (int i = 0; i < n; i++)
        begin
            @(negedge clock);
            step_events(br_ok, wb_ok);
        end
        @(negedge clock);
        drive_idle();
    endtask

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_cnt(input string name, input bpmon_pkg::cnt_t got,
                             input bpmon_pkg::cnt_t exp);
        if (got !== exp)
            fail_now($sformatf("ERROR %s got %h exp %h", name, got, exp));
    endtask

    task automatic check_sig(input string name, input bpmon_pkg::sig_t got,
                             input bpmon_pkg::sig_t exp);
        if (got !== exp)
            fail_now($sformatf("ERROR %s got %h exp %h", name, got, exp));
    endtask

    task automatic check_resp(input string name, input bpmon_pkg::resp_t got,
                              input bpmon_pkg::resp_t exp);
        if (got !== exp)
            fail_now($sformatf("ERROR %s got %h exp %h", name, got, exp));
    endtask

    function automatic logic [7:0] word_addr(input int c, input int k);
        return 8'(c * 32 + k * 4);
    endfunction

    function automatic bpmon_pkg::cnt_t exp_word(input int c, input int k);
        case (k)
            0: return m_wb_cnt[c];
            1: return m_wb_sig[c];
            2: return m_br_cnt[c];
            3: return m_br_err[c];
            4: return m_br_rec[c];
            default: return m_br_sig[c];
        endcase
    endfunction

    // busy keeps events flowing while the read is stalled
    task automatic read_word(input logic [7:0] addr, input int stall, input bit busy,
                             output bpmon_pkg::cnt_t data, output bpmon_pkg::resp_t resp);
        int                 wait_cnt;
        bpmon_pkg::axil_r_t held;
        ar.arvalid = 1'b1;
        ar.araddr = addr;
        rready = 1'b0;
        wait_cnt = 0;
        while (!arready)
        begin
            @(negedge clock);
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT)
                fail_now("timeout waiting for arready");
        end
        @(negedge clock);
        ar.arvalid = 1'b0;
        wait_cnt = 0;
        while (!r.rvalid)
        begin
            @(negedge clock);
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT)
                fail_now("timeout waiting for rvalid");
        end
        held = r;
        if (arready)
            fail_now("arready high while a read response was pending");
        for (int i = 0; i < stall; i++)
        begin
            if (busy)
                step_events(1'b1, 1'b0);
            @(negedge clock);
            if (!r.rvalid)
                fail_now("rvalid dropped while rready was low");
            if (arready)
                fail_now("arready high while a read response was pending");
            check_cnt("rdata", r.rdata, held.rdata);
            check_resp("rresp", r.rresp, held.rresp);
        end
        if (busy)
            drive_idle();
        rready = 1'b1;
        @(negedge clock);
        rready = 1'b0;
        wait_cnt = 0;
        while (r.rvalid)
        begin
            @(negedge clock);
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT)
                fail_now("timeout waiting for rvalid to fall after handshake");
        end
        data = held.rdata;
        resp = held.rresp;
    endtask

    task automatic check_all();
        bpmon_pkg::cnt_t       data;
        bpmon_pkg::resp_t      resp;
        bpmon_pkg::class_cnt_t got_wb;
        bpmon_pkg::class_cnt_t got_br;
        string                 name;
        for (int c = 0; c < `BPMON_NUM_CLASS; c++)
        begin
            for (int k = 0; k < 6; k++)
            begin
                name = $sformatf("%s[%0d]", kind_names[k], c);
                read_word(word_addr(c, k), int'(take_bits(2)), 1'b0, data, resp);
                check_resp(name, resp, bpmon_pkg::OKAY);
                if (k == 1 || k == 5)
                    check_sig(name, data, exp_word(c, k));
                else
                    check_cnt(name, data, exp_word(c, k));
                if (k == 0)
                    got_wb[c] = data;
                if (k == 2)
                    got_br[c] = data;
            end
        end
        check_cnt("wb_cnt[0] sum", got_wb[0], got_wb[1] + got_wb[2] + got_wb[3]);
        check_cnt("br_cnt[0] sum", got_br[0], got_br[1] + got_br[2] + got_br[3]);
    endtask

    task automatic check_decerr(input logic [7:0] addr);
        bpmon_pkg::cnt_t  data;
        bpmon_pkg::resp_t resp;
        read_word(addr, 0, 1'b0, data, resp);
        check_cnt($sformatf("rdata@%h", addr), data, '0);
        check_resp($sformatf("rresp@%h", addr), resp, bpmon_pkg::DECERR);
    endtask

    initial
    begin
        bpmon_pkg::cnt_t  data;
        bpmon_pkg::resp_t resp;
        bpmon_pkg::cnt_t  exp;
        clock = 1'b0;
        reset = 1'b1;
        lfsr = 32'h47ba_35ef;
        ar = '0;
        rready = 1'b0;
        drive_idle();
        m_wb_cnt = '0;
        m_wb_sig = '0;
        m_br_cnt = '0;
        m_br_err = '0;
        m_br_rec = '0;
        m_br_sig = '0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        if (r.rvalid || !arready)
            fail_now("read channel not idle after reset");
        check_all();
        run_burst(200, 1'b0, 1'b0);
        check_all();
        run_burst(200, 1'b1, 1'b0);
        check_all();
        // flush and br event in one cycle
        @(negedge clock);
        br_evt = make_event(2'd1, take_bits(32));
        wb_evt = make_event(2'd3, take_bits(32));
        wb_evt.cancel = 1'b1;
        model_update(br_evt, wb_evt);
        @(negedge clock);
        drive_idle();
        check_all();
        run_burst(300, 1'b1, 1'b1);
        check_all();
        // snapshot taken at address acceptance
        exp = m_br_cnt[0];
        read_word(word_addr(0, 2), 4 + int'(take_bits(3)), 1'b1, data, resp);
        check_cnt("br_cnt[0] stalled", data, exp);
        check_all();
        for (int c = 0; c < `BPMON_NUM_CLASS; c++)
        begin
            check_decerr(word_addr(c, 6));
            check_decerr(word_addr(c, 7));
            check_decerr(word_addr(c, 1) + 8'(c % 3 + 1));
        end
        check_decerr(8'h80);
        check_decerr(8'he4);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* src.f */
+incdir+include
verilog/bpmon_pkg.sv
verilog/bpmon_wb_tracker.sv
verilog/bpmon_br_tracker.sv
verilog/bpmon_axil_regs.sv
verilog/bpmon_top.sv
tb/bpmon_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= bpmon_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
